//--- rtl/trace_cfg.svh
// sizing for the trace front end; FIFO depth must be a power of two, rule count at most 4
`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

// match window length in bytes
`define TRACE_BUF_BYTES 8

// number of pattern/mask rules, rule index is 2 bits
`define TRACE_NUM_RULES 4

// per-rule match counter, saturating
`define TRACE_COUNT_W 8

// byte offset of an event since the trigger
`define TRACE_OFFSET_W 12

// event FIFO entries
`define TRACE_FIFO_DEPTH 16

`define TRACE_CAPLEN_W 8     // events per capture
`define TRACE_TRIG_DELAY_W 8 // cycles before the trigger pulse
`define TRACE_TRIG_WIDTH_W 8 // trigger pulse length in cycles

`endif

//--- rtl/trace_pkg.sv
// types for the trace window and the rule bank; sizes come from trace_cfg.svh
`include "trace_cfg.svh"

package trace_pkg;

  // newest byte sits in the low 8 bits
  typedef logic [`TRACE_BUF_BYTES*8-1:0] trace_window_t;

  // one bit per rule, bit 0 is rule 0
  typedef logic [`TRACE_NUM_RULES-1:0] rule_vec_t;

  // one full window per rule, used for patterns and masks
  typedef trace_window_t [`TRACE_NUM_RULES-1:0] rule_word_array_t;

  // match counters, one per rule
  typedef logic [`TRACE_NUM_RULES-1:0][`TRACE_COUNT_W-1:0] count_array_t;

endpackage

//--- rtl/capture_pkg.sv
// types for captured match events; a record is rule index above the byte offset
`include "trace_cfg.svh"

package capture_pkg;

  // index of the lowest matching rule
  typedef logic [$clog2(`TRACE_NUM_RULES)-1:0] rule_idx_t;

  // one FIFO entry, 14 bits with the default sizing
  typedef struct packed {
    rule_idx_t                  rule;
    logic [`TRACE_OFFSET_W-1:0] offset;  // bytes since the trigger byte
  } event_rec_t;

endpackage

//--- rtl/trace_shift_buffer.sv
// one byte per trace_valid, no stall; window holds the last bytes with the newest in the low bits
`timescale 1ns/1ps

module trace_shift_buffer (
  input  logic                     fe_clk,
  input  logic                     reset,
  input  logic [7:0]               trace_byte,
  input  logic                     trace_valid,
  output trace_pkg::trace_window_t window,
  output logic                     window_update
);

  localparam int WIN_W = $bits(trace_pkg::trace_window_t);

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      window        <= '0;
      window_update <= 1'b0;
    end else begin
      window_update <= trace_valid;  // window already holds the byte when this is seen
      if (trace_valid) begin
        window <= {window[WIN_W-9:0], trace_byte};  // oldest byte drops off the top
      end
    end
  end

  // an X byte would poison every rule compare downstream
  property p_byte_known;
    @(posedge fe_clk) disable iff (reset)
      trace_valid |-> !$isunknown(trace_byte);
  endproperty

  a_byte_known: assert property (p_byte_known)
    else $error("trace_byte unknown while trace_valid");

endmodule

//--- rtl/pattern_matcher.sv
// all rules compared in parallel on each window update; counters saturate and clear on clear_counts
`timescale 1ns/1ps
`include "trace_cfg.svh"

module pattern_matcher (
  input  logic                        fe_clk,
  input  logic                        reset,
  input  trace_pkg::trace_window_t    window,
  input  logic                        window_update,
  input  trace_pkg::rule_word_array_t pattern,
  input  trace_pkg::rule_word_array_t mask,
  input  trace_pkg::rule_vec_t        rule_enable,
  input  logic                        clear_counts,
  output trace_pkg::rule_vec_t        match_vec,
  output logic                        match_pulse,
  output trace_pkg::count_array_t     match_count
);

  localparam int NUM_RULES = `TRACE_NUM_RULES;

  trace_pkg::rule_vec_t hit;

  // mask bit 1 means the window bit must equal the pattern bit
  always_comb begin
    for (int i = 0; i < NUM_RULES; i++) begin
      hit[i] = rule_enable[i] && (((window ^ pattern[i]) & mask[i]) == '0);
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      match_vec   <= '0;
      match_pulse <= 1'b0;
    end else begin
      match_vec   <= window_update ? hit : '0;  // only meaningful with match_pulse
      match_pulse <= window_update && (hit != '0);
    end
  end

  // counters step on the same edge as match_vec
  always_ff @(posedge fe_clk) begin
    if (reset || clear_counts) begin
      match_count <= '0;
    end else begin
      for (int i = 0; i < NUM_RULES; i++) begin
        if (window_update && hit[i] && (match_count[i] != '1)) begin
          match_count[i] <= match_count[i] + `TRACE_COUNT_W'(1);
        end
      end
    end
  end

  // a match must come from the window update one cycle earlier
  property p_pulse_has_rule;
    @(posedge fe_clk) disable iff (reset)
      match_pulse |-> ($past(window_update) && (match_vec != '0));
  endproperty

  a_pulse_has_rule: assert property (p_pulse_has_rule)
    else $error("match_pulse without a window update or matching rule");

endmodule

//--- rtl/capture_ctrl.sv
// push and trigger_match are combinational from match_pulse; capture_len of 0 acts like 1
`timescale 1ns/1ps
`include "trace_cfg.svh"

module capture_ctrl (
  input  logic                         fe_clk,
  input  logic                         reset,
  input  logic                         arm,
  input  trace_pkg::rule_vec_t         trig_enable,
  input  logic [`TRACE_CAPLEN_W-1:0]   capture_len,
  input  logic                         window_update,
  input  trace_pkg::rule_vec_t         match_vec,
  input  logic                         match_pulse,
  input  logic                         fifo_full,
  output logic                         push,
  output capture_pkg::event_rec_t      push_data,
  output logic                         trigger_match,
  output logic                         capturing,
  output logic                         overflow
);

  localparam int OFF_W = `TRACE_OFFSET_W;
  localparam int LEN_W = `TRACE_CAPLEN_W;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ARMED,
    ST_CAPTURING
  } cap_state_t;

  cap_state_t             state;
  logic [OFF_W-1:0]       offset;
  logic [LEN_W-1:0]       ev_count;
  logic [LEN_W:0]         count_next;
  logic                   trig_hit;
  logic                   cap_hit;
  logic                   refused;
  capture_pkg::rule_idx_t low_rule;

  // lowest set bit wins, so scan downwards
  always_comb begin
    low_rule = '0;
    for (int i = `TRACE_NUM_RULES - 1; i >= 0; i--) begin
      if (match_vec[i]) begin
        low_rule = capture_pkg::rule_idx_t'(i);
      end
    end
  end

  assign trig_hit   = (state == ST_ARMED) && match_pulse && ((match_vec & trig_enable) != '0);
  assign cap_hit    = (state == ST_CAPTURING) && match_pulse;
  assign push       = (trig_hit || cap_hit) && !fifo_full;
  assign refused    = (trig_hit || cap_hit) && fifo_full;
  assign count_next = {1'b0, ev_count} + (LEN_W+1)'(1);

  assign trigger_match    = trig_hit;
  assign push_data.rule   = low_rule;
  assign push_data.offset = trig_hit ? '0 : offset;  // trigger byte is offset 0
  assign capturing        = (state == ST_CAPTURING);

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      state    <= ST_IDLE;
      offset   <= '0;
      ev_count <= '0;
      overflow <= 1'b0;
    end else if (arm) begin
      state    <= ST_ARMED;  // re-arm also drops a running capture
      offset   <= '0;
      ev_count <= '0;
      overflow <= 1'b0;
    end else begin
      // a byte updating the window in the trigger cycle is already past the trigger
      if (trig_hit) begin
        offset <= window_update ? OFF_W'(1) : '0;
      end else if ((state == ST_CAPTURING) && window_update && (offset != '1)) begin
        offset <= offset + OFF_W'(1);
      end

      if (push) begin
        ev_count <= count_next[LEN_W-1:0];
        if (count_next >= {1'b0, capture_len}) begin
          state <= ST_IDLE;
        end else if (trig_hit) begin
          state <= ST_CAPTURING;
        end
      end else if (refused) begin
        overflow <= 1'b1;  // sticky until next arm
        state    <= ST_IDLE;
      end
    end
  end

  // the FIFO never sees a write it would have to drop
  property p_no_push_when_full;
    @(posedge fe_clk) disable iff (reset)
      push |-> !fifo_full;
  endproperty

  a_no_push_when_full: assert property (p_no_push_when_full)
    else $error("event push while FIFO full");

endmodule

//--- rtl/event_fifo.sv
// show-ahead FIFO, head valid while fifo_empty is low; depth must be a power of two
`timescale 1ns/1ps
`include "trace_cfg.svh"

module event_fifo (
  input  logic                    fe_clk,
  input  logic                    reset,
  input  logic                    push,
  input  capture_pkg::event_rec_t push_data,
  input  logic                    pop,
  output capture_pkg::event_rec_t head,
  output logic                    fifo_full,
  output logic                    fifo_empty
);

  localparam int DEPTH = `TRACE_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  capture_pkg::event_rec_t mem [DEPTH];
  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  logic [PTR_W:0]          count;  // one extra bit so full and empty differ
  logic                    do_push;
  logic                    do_pop;

  assign do_push    = push && !fifo_full;
  assign do_pop     = pop && !fifo_empty;
  assign fifo_full  = (count == (PTR_W+1)'(DEPTH));
  assign fifo_empty = (count == '0);
  assign head       = mem[rd_ptr];

  always_ff @(posedge fe_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + PTR_W'(1);  // wraps at depth
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + (PTR_W+1)'(1);
        2'b01:   count <= count - (PTR_W+1)'(1);
        default: count <= count;  // both or neither
      endcase
    end
  end

  // reader outside must watch fifo_empty before popping
  property p_no_pop_when_empty;
    @(posedge fe_clk) disable iff (reset)
      pop |-> !fifo_empty;
  endproperty

  a_no_pop_when_empty: assert property (p_no_pop_when_empty)
    else $error("event FIFO pop while empty");

endmodule

//--- rtl/trigger_gen.sv
// single pulse per trigger, delay and width sampled when they are needed; retrigger while busy is lost
`timescale 1ns/1ps
`include "trace_cfg.svh"

module trigger_gen (
  input  logic                           fe_clk,
  input  logic                           reset,
  input  logic                           trigger_match,
  input  logic [`TRACE_TRIG_DELAY_W-1:0] trig_delay,
  input  logic [`TRACE_TRIG_WIDTH_W-1:0] trig_width,
  output logic                           trig_out
);

  localparam int DLY_W = `TRACE_TRIG_DELAY_W;
  localparam int WID_W = `TRACE_TRIG_WIDTH_W;
  localparam int CNT_W = (DLY_W > WID_W) ? DLY_W : WID_W;

  typedef enum logic [1:0] {
    TG_IDLE,
    TG_DELAY,
    TG_PULSE
  } trig_state_t;

  trig_state_t      state;
  logic [CNT_W-1:0] cnt;  // shared by the delay and width phases

  assign trig_out = (state == TG_PULSE);

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      state <= TG_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        TG_IDLE: begin
          if (trigger_match && (trig_width != '0)) begin
            if (trig_delay == '0) begin
              state <= TG_PULSE;  // high on the next cycle
              cnt   <= CNT_W'(trig_width) - CNT_W'(1);
            end else begin
              state <= TG_DELAY;
              cnt   <= CNT_W'(trig_delay) - CNT_W'(1);
            end
          end
        end
        TG_DELAY: begin
          if (cnt == '0) begin
            state <= (trig_width == '0) ? TG_IDLE : TG_PULSE;  // width changed mid delay
            cnt   <= CNT_W'(trig_width) - CNT_W'(1);
          end else begin
            cnt <= cnt - CNT_W'(1);
          end
        end
        TG_PULSE: begin
          if (cnt == '0) begin
            state <= TG_IDLE;
          end else begin
            cnt <= cnt - CNT_W'(1);
          end
        end
        default: state <= TG_IDLE;
      endcase
    end
  end

endmodule

//--- rtl/trace_top.sv
// trace front end on fe_clk only; arm also clears the match counters, pop only while not empty
`timescale 1ns/1ps
`include "trace_cfg.svh"

module trace_top (
  input  logic                           fe_clk,
  input  logic                           reset,
  input  logic [7:0]                     trace_byte,
  input  logic                           trace_valid,
  input  trace_pkg::rule_word_array_t    pattern,
  input  trace_pkg::rule_word_array_t    mask,
  input  trace_pkg::rule_vec_t           rule_enable,
  input  trace_pkg::rule_vec_t           trig_enable,
  input  logic                           arm,
  input  logic [`TRACE_CAPLEN_W-1:0]     capture_len,
  input  logic [`TRACE_TRIG_DELAY_W-1:0] trig_delay,
  input  logic [`TRACE_TRIG_WIDTH_W-1:0] trig_width,
  input  logic                           fifo_pop,
  output capture_pkg::rule_idx_t         fifo_rule,
  output logic [`TRACE_OFFSET_W-1:0]     fifo_offset,
  output logic                           fifo_empty,
  output logic                           overflow,
  output logic                           capturing,
  output logic                           trig_out,
  output trace_pkg::count_array_t        match_count
);

  trace_pkg::trace_window_t window;
  logic                     window_update;
  trace_pkg::rule_vec_t     match_vec;
  logic                     match_pulse;
  logic                     push;
  capture_pkg::event_rec_t  push_data;
  capture_pkg::event_rec_t  fifo_head;
  logic                     fifo_full;
  logic                     trigger_match;

  assign fifo_rule   = fifo_head.rule;
  assign fifo_offset = fifo_head.offset;

  trace_shift_buffer u_shift (
    .fe_clk        (fe_clk),
    .reset         (reset),
    .trace_byte    (trace_byte),
    .trace_valid   (trace_valid),
    .window        (window),
    .window_update (window_update)
  );

  pattern_matcher u_match (
    .fe_clk        (fe_clk),
    .reset         (reset),
    .window        (window),
    .window_update (window_update),
    .pattern       (pattern),
    .mask          (mask),
    .rule_enable   (rule_enable),
    .clear_counts  (arm),          // counters restart with each capture
    .match_vec     (match_vec),
    .match_pulse   (match_pulse),
    .match_count   (match_count)
  );

  capture_ctrl u_capture (
    .fe_clk        (fe_clk),
    .reset         (reset),
    .arm           (arm),
    .trig_enable   (trig_enable),
    .capture_len   (capture_len),
    .window_update (window_update),
    .match_vec     (match_vec),
    .match_pulse   (match_pulse),
    .fifo_full     (fifo_full),
    .push          (push),
    .push_data     (push_data),
    .trigger_match (trigger_match),
    .capturing     (capturing),
    .overflow      (overflow)
  );

  event_fifo u_fifo (
    .fe_clk     (fe_clk),
    .reset      (reset),
    .push       (push),
    .push_data  (push_data),
    .pop        (fifo_pop),
    .head       (fifo_head),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty)
  );

  trigger_gen u_trig (
    .fe_clk        (fe_clk),
    .reset         (reset),
    .trigger_match (trigger_match),
    .trig_delay    (trig_delay),
    .trig_width    (trig_width),
    .trig_out      (trig_out)
  );

endmodule

//--- sim/trace_top_tb.sv
// cycle-accurate model beside the DUT; the FIFO is popped only while draining after a capture
`timescale 1ns/1ps
`include "trace_cfg.svh"

module trace_top_tb;

  localparam int MAX_CYCLES = 6000;  // about three times the stimulus length
  localparam int DEPTH      = `TRACE_FIFO_DEPTH;
  localparam int OFF_MAX    = (1 << `TRACE_OFFSET_W) - 1;

  typedef enum logic [1:0] {M_IDLE, M_ARMED, M_CAP} model_state_t;

  logic                           fe_clk = 1'b0;
  logic                           reset;
  logic [7:0]                     trace_byte;
  logic                           trace_valid;
  trace_pkg::rule_word_array_t    pattern;
  trace_pkg::rule_word_array_t    mask;
  trace_pkg::rule_vec_t           rule_enable;
  trace_pkg::rule_vec_t           trig_enable;
  logic                           arm;
  logic [`TRACE_CAPLEN_W-1:0]     capture_len;
  logic [`TRACE_TRIG_DELAY_W-1:0] trig_delay;
  logic [`TRACE_TRIG_WIDTH_W-1:0] trig_width;
  logic                           fifo_pop;
  capture_pkg::rule_idx_t         fifo_rule;
  logic [`TRACE_OFFSET_W-1:0]     fifo_offset;
  logic                           fifo_empty;
  logic                           overflow;
  logic                           capturing;
  logic                           trig_out;
  trace_pkg::count_array_t        match_count;

  // model state, all updated on the same edges as the DUT
  trace_pkg::trace_window_t  m_window;
  logic                      m_update;
  trace_pkg::rule_vec_t      m_match;
  trace_pkg::count_array_t   m_count;
  model_state_t              m_state;
  logic                      m_overflow;
  logic                      m_trig_out;
  int                        m_idx;        // index of the newest byte in the window
  int                        m_match_idx;
  int                        m_trig_idx;
  int                        m_evc;
  int                        m_occ;        // FIFO occupancy
  int                        m_trig_start;
  int                        m_trig_end;
  capture_pkg::event_rec_t   exp_q[$];
  int                        cyc = 0;
  int                        err_count = 0;
  int                        tests_ok = 0;
  int                        tests_bad = 0;
  int                        seed = 32'ha86e;

  trace_top u_trace_top (.*);

  always #20 fe_clk = ~fe_clk;

  always @(posedge fe_clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles without finishing", cyc);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic flag_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    err_count++;
  endtask

  // masked compare taken straight from the rule definition
  function automatic logic rule_hit(trace_pkg::trace_window_t w, trace_pkg::trace_window_t p,
                                    trace_pkg::trace_window_t m);
    return (w & m) == (p & m);
  endfunction

  function automatic capture_pkg::rule_idx_t lowest_rule(trace_pkg::rule_vec_t v);
    int r;
    r = -1;
    for (int i = 0; i < `TRACE_NUM_RULES; i++) begin
      if (v[i] && (r < 0)) begin
        r = i;
      end
    end
    return capture_pkg::rule_idx_t'(r);
  endfunction

  always @(posedge fe_clk) begin : model_step
    trace_pkg::rule_vec_t    hits;
    capture_pkg::event_rec_t ev;
    logic                    have_ev;
    int                      occ_next;
    int                      t_start;
    int                      t_end;
    if (reset) begin
      m_window     <= '0;
      m_update     <= 1'b0;
      m_match      <= '0;
      m_count      <= '0;
      m_state      <= M_IDLE;
      m_overflow   <= 1'b0;
      m_trig_out   <= 1'b0;
      m_idx        <= 0;
      m_match_idx  <= 0;
      m_trig_idx   <= 0;
      m_evc        <= 0;
      m_occ        <= 0;
      m_trig_start <= -1;
      m_trig_end   <= -1;
      exp_q.delete();
    end else begin
      hits = '0;
      for (int i = 0; i < `TRACE_NUM_RULES; i++) begin
        hits[i] = m_update && rule_enable[i] && rule_hit(m_window, pattern[i], mask[i]);
      end
      if (trace_valid) begin
        m_window <= {m_window[$bits(m_window)-9:0], trace_byte};
        m_idx    <= m_idx + 1;
      end
      m_update    <= trace_valid;
      m_match     <= hits;
      m_match_idx <= m_idx;
      for (int i = 0; i < `TRACE_NUM_RULES; i++) begin
        if (arm) begin
          m_count[i] <= '0;
        end else if (hits[i] && (m_count[i] != '1)) begin
          m_count[i] <= m_count[i] + 1'b1;  // saturates at 255
        end
      end
      have_ev  = 1'b0;
      ev       = '0;
      occ_next = m_occ - (fifo_pop ? 1 : 0);
      t_start  = m_trig_start;
      t_end    = m_trig_end;
      if (arm) begin
        m_state    <= M_ARMED;
        m_evc      <= 0;
        m_overflow <= 1'b0;
      end else if (m_match != '0) begin
        ev.rule = lowest_rule(m_match);
        if ((m_state == M_ARMED) && ((m_match & trig_enable) != '0)) begin
          have_ev    = 1'b1;
          m_trig_idx <= m_match_idx;
          if ((trig_width != '0) && (cyc > m_trig_end)) begin
            t_start = cyc + trig_delay;
            t_end   = t_start + trig_width;
          end
        end else if (m_state == M_CAP) begin
          have_ev   = 1'b1;
          ev.offset = `TRACE_OFFSET_W'(((m_match_idx - m_trig_idx) > OFF_MAX) ?
                                       OFF_MAX : (m_match_idx - m_trig_idx));
        end
        if (have_ev && (m_occ < DEPTH)) begin
          exp_q.push_back(ev);
          occ_next++;
          m_evc   <= m_evc + 1;
          m_state <= ((m_evc + 1) >= capture_len) ? M_IDLE : M_CAP;
        end else if (have_ev) begin
          m_overflow <= 1'b1;  // push refused
          m_state    <= M_IDLE;
        end
      end
      m_occ        <= occ_next;
      m_trig_start <= t_start;
      m_trig_end   <= t_end;
      m_trig_out   <= (cyc >= t_start) && (cyc < t_end);
    end
  end

  a_counts: assert property (@(posedge fe_clk) disable iff (reset) match_count == m_count)
    else flag_error("match_count differs from model");
  a_capturing: assert property (@(posedge fe_clk) disable iff (reset)
    capturing == (m_state == M_CAP)) else flag_error("capturing differs from model");
  a_overflow: assert property (@(posedge fe_clk) disable iff (reset) overflow == m_overflow)
    else flag_error("overflow differs from model");
  a_empty: assert property (@(posedge fe_clk) disable iff (reset) fifo_empty == (m_occ == 0))
    else flag_error("fifo_empty differs from model occupancy");
  a_trig: assert property (@(posedge fe_clk) disable iff (reset) trig_out == m_trig_out)
    else flag_error("trig_out differs from model pulse timing");

  task automatic send_byte(input logic [7:0] b);
    trace_valid <= 1'b1;
    trace_byte  <= b;
    @(posedge fe_clk);
  endtask

  task automatic idle(input int n);
    trace_valid <= 1'b0;
    repeat (n) @(posedge fe_clk);
  endtask

  task automatic send_random(input int n);
    repeat (n) begin
      if (($random(seed) & 3) == 0) begin
        idle(1);  // occasional gap in the stream
      end
      send_byte(8'($random(seed)));
    end
  endtask

  task automatic run_capture(input logic [`TRACE_CAPLEN_W-1:0] len,
                             input logic [`TRACE_TRIG_DELAY_W-1:0] dly,
                             input logic [`TRACE_TRIG_WIDTH_W-1:0] wid,
                             input int tail);
    trig_enable <= 4'b0001;
    capture_len <= len;
    trig_delay  <= dly;
    trig_width  <= wid;
    arm         <= 1'b1;
    @(posedge fe_clk);
    arm <= 1'b0;
    send_random(20);
    send_byte(8'h5a);  // trigger byte for rule 0
    send_random(tail);
    idle(4);
    while (capturing) @(posedge fe_clk);
    idle(int'(dly) + int'(wid) + 2);  // trigger pulse done
  endtask

  // head checked mid-cycle, one pop every other cycle
  task automatic drain_fifo(output int popped);
    capture_pkg::event_rec_t exp;
    popped = 0;
    while (!fifo_empty) begin
      fifo_pop <= 1'b1;
      @(negedge fe_clk);
      if (exp_q.size() == 0) begin
        flag_error("FIFO holds an event the model never produced");
      end else begin
        exp = exp_q.pop_front();
        assert ((fifo_rule == exp.rule) && (fifo_offset == exp.offset))
          else flag_error($sformatf("event rule %0d offset %0d, expected rule %0d offset %0d",
                                    fifo_rule, fifo_offset, exp.rule, exp.offset));
      end
      popped++;
      @(posedge fe_clk);
      fifo_pop <= 1'b0;
      @(posedge fe_clk);
    end
    assert (exp_q.size() == 0) else flag_error("model expects events the FIFO never delivered");
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  initial begin
    int base;
    int popped;
    reset       = 1'b1;
    trace_byte  = '0;
    trace_valid = 1'b0;
    pattern[0]  = 64'h5a;
    mask[0]     = 64'hff;
    pattern[1]  = 64'h80;  // bit 7 of the newest byte
    mask[1]     = 64'h80;
    pattern[2]  = 64'h1122_3344_5566_7788;
    mask[2]     = 64'h00ff_00ff;  // bytes 0 and 2 only
    pattern[3]  = '0;
    mask[3]     = '0;  // would hit every window if enabled
    rule_enable = 4'b0011;
    trig_enable = '0;
    arm         = 1'b0;
    capture_len = 8'd5;
    trig_delay  = '0;
    trig_width  = '0;
    fifo_pop    = 1'b0;
    repeat (10) @(posedge fe_clk);
    reset <= 1'b0;
    @(posedge fe_clk);

    base = err_count;
    assert (!capturing && !trig_out && !overflow && fifo_empty && (match_count == '0))
      else flag_error("outputs not idle after reset");
    end_test("reset", base);

    base = err_count;
    send_random(600);
    idle(4);
    assert (match_count[1] == 8'hff) else flag_error("rule 1 count did not saturate at 255");
    end_test("counting", base);

    base = err_count;
    rule_enable <= 4'b0111;
    arm         <= 1'b1;
    @(posedge fe_clk);
    arm <= 1'b0;
    repeat (6) begin
      send_byte(8'h66);
      send_byte(8'($random(seed)));  // masked out
      send_byte(8'h88);
      send_random(5);
    end
    idle(4);
    assert (match_count[2] >= 6) else flag_error("masked rule 2 missed spliced sequences");
    assert (match_count[3] == 0) else flag_error("disabled rule 3 counted");
    end_test("masking", base);

    base = err_count;
    run_capture(8'd5, 8'd3, 8'd4, 40);
    drain_fifo(popped);
    assert (popped == 5) else flag_error($sformatf("captured %0d events, expected 5", popped));
    end_test("capture", base);

    base = err_count;
    run_capture(8'd2, 8'd0, 8'd2, 30);
    drain_fifo(popped);
    assert (popped == 2) else flag_error($sformatf("captured %0d events, expected 2", popped));
    end_test("trigger pulse", base);

    base = err_count;
    run_capture(8'd40, 8'd1, 8'd1, 100);
    assert (overflow) else flag_error("overflow did not rise with the FIFO full");
    arm <= 1'b1;
    @(posedge fe_clk);
    arm <= 1'b0;
    idle(2);
    assert (!overflow && (match_count == '0)) else flag_error("arm did not clear overflow");
    drain_fifo(popped);
    assert (popped == DEPTH) else flag_error($sformatf("FIFO held %0d events", popped));
    end_test("overflow", base);

    $display("summary: %0d tests ok, %0d tests with errors", tests_ok, tests_bad);
    if ((tests_bad == 0) && (err_count == 0)) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- trace_top.f
+incdir+rtl
rtl/trace_pkg.sv
rtl/capture_pkg.sv
rtl/trace_shift_buffer.sv
rtl/pattern_matcher.sv
rtl/capture_ctrl.sv
rtl/event_fifo.sv
rtl/trigger_gen.sv
rtl/trace_top.sv
sim/trace_top_tb.sv
